// ==== Makefile ====
# Verilator build, run, lint and clean for the tcb subsystem

VERILATOR   ?= verilator
TOP         ?= tcb_subsys_tb
DUT_TOP     ?= tcb_subsys
FILELIST    ?= verilog.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing -Wno-fatal
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_MSG    ?= Test OK

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only if the pass message appears as a line of its own
run: build
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/tcb_bus_pkg.sv ====
/* reference mode bus types
   request and response as seen by the manager */
`default_nettype none

`include "tcb_consts.svh"

package tcb_bus_pkg;

  ////////////////////
  // transfer size
  ////////////////////

  // bytes = 2**code, code 3 is not a legal size
  typedef logic [1:0] tcb_siz_t;

  ////////////////////
  // request
  ////////////////////

  typedef struct packed {
    // write enable
    logic                  wen;
    // endianness, 1 for big endian
    logic                  ndn;
    tcb_siz_t              siz;
    // byte address
    logic [`TCB_ADR_W-1:0] adr;
    // write data, right aligned
    logic [`TCB_DAT_W-1:0] wdt;
  } tcb_req_t;

  ////////////////////
  // response
  ////////////////////

  typedef struct packed {
    // read data, right aligned
    logic [`TCB_DAT_W-1:0] rdt;
    // error status
    logic                  sts;
  } tcb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/tcb_consts.svh ====
/* tightly coupled bus geometry constants
   address width, byte lanes, lane width and memory depth */
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

////////////////////
// bus geometry
////////////////////

// byte address width
`define TCB_ADR_W 12
// number of byte lanes
`define TCB_BEN 4
// bits per lane
`define TCB_UNT 8

// derived widths
`define TCB_DAT_W (`TCB_BEN*`TCB_UNT)
// low address bits selecting a lane
`define TCB_LO_W ($clog2(`TCB_BEN))
// word index width
`define TCB_WRD_W (`TCB_ADR_W-`TCB_LO_W)

// memory depth in words, covers the whole address space
`define TCB_MEM_WORDS 1024

`endif

// ==== hw/tcb_mem.sv ====
/* on-chip single port memory
   per lane writes, registered read one cycle after the request */
`timescale 1ns/1ns
`default_nettype none

`include "tcb_consts.svh"

module tcb_mem
  import tcb_mem_pkg::*;
(
  input  logic     clk,
  // request from the steering block
  input  logic     mem_vld,
  input  mem_req_t mem_req,
  // read lanes
  output mem_dat_t rdt
);

  ////////////////////
  // storage
  ////////////////////

  // word array, contents undefined until written
  mem_dat_t mem [`TCB_MEM_WORDS];

  ////////////////////
  // write
  ////////////////////

  // lanes written only under their byte enable
  always_ff @(posedge clk) begin
    if (mem_vld && mem_req.wen) begin
      for (int i = 0; i < `TCB_BEN; i++) begin
        if (mem_req.ben[i]) begin
          mem[mem_req.adr][i] <= mem_req.wdt[i];
        end
      end
    end
  end

  ////////////////////
  // read
  ////////////////////

  // registered on every valid request
  // read first, same word write shows old data
  always_ff @(posedge clk) begin
    if (mem_vld) begin
      rdt <= mem[mem_req.adr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcb_mem_pkg.sv ====
/* memory side types
   lane request to the memory and the transfer context for the response */
`default_nettype none

`include "tcb_consts.svh"

package tcb_mem_pkg;
  import tcb_bus_pkg::*;

  // data as byte lanes, lane 0 in the low byte
  typedef logic [`TCB_BEN-1:0][`TCB_UNT-1:0] mem_dat_t;

  ////////////////////
  // memory request
  ////////////////////

  typedef struct packed {
    logic                  wen;
    // word index
    logic [`TCB_WRD_W-1:0] adr;
    // per lane write enables
    logic [`TCB_BEN-1:0]   ben;
    mem_dat_t              wdt;
  } mem_req_t;

  ////////////////////
  // transfer context
  ////////////////////

  // kept for one cycle, read data steering and status
  typedef struct packed {
    logic                 wen;
    logic                 ndn;
    tcb_siz_t             siz;
    // address modulo lanes
    logic [`TCB_LO_W-1:0] lo;
    // misaligned
    logic                 mal;
  } tcb_ctx_t;

endpackage

`default_nettype wire

// ==== hw/tcb_req_steer.sv ====
/* request steering, reference mode to memory mode
   alignment check, write lanes, byte enables and the response context */
`timescale 1ns/1ns
`default_nettype none

`include "tcb_consts.svh"

module tcb_req_steer
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  // reference side request
  input  logic     vld,
  input  tcb_req_t req,
  // memory side request
  output logic     mem_vld,
  output mem_req_t mem_req,
  // context for the response stage
  output logic     ctx_vld,
  output tcb_ctx_t ctx
);

  // low address bits
  logic [`TCB_LO_W-1:0] lo;
  // transfer size in bytes, zero for code 3
  logic [`TCB_LO_W:0]   siz_n;
  logic                 mal;
  // right aligned write bytes
  mem_dat_t             wdt_b;

  assign lo    = req.adr[`TCB_LO_W-1:0];
  assign siz_n = (`TCB_LO_W+1)'(1) << req.siz;
  assign wdt_b = req.wdt;

  ////////////////////
  // alignment
  ////////////////////

  // same decode for reads and writes
  always_comb begin
    case (req.siz)
      2'd0:    mal = 1'b0;
      2'd1:    mal = lo[0];
      2'd2:    mal = |lo;
      // illegal size
      default: mal = 1'b1;
    endcase
  end

  ////////////////////
  // write lanes
  ////////////////////

  for (genvar i = 0; i < `TCB_BEN; i++) begin : g_lane
    // right aligned byte landing in lane i
    logic [`TCB_LO_W-1:0] sel;

    always_comb begin
      if (req.ndn) begin
        // big endian, byte k goes to lane lo+s-1-k
        sel = `TCB_LO_W'(lo + siz_n - 1 - i);
      end else begin
        // little endian, byte k goes to lane lo+k
        sel = `TCB_LO_W'(i - lo);
      end
    end

    assign mem_req.wdt[i] = wdt_b[sel];
    // only bytes below the size, nothing on misalignment
    assign mem_req.ben[i] = ~mal & ({1'b0, sel} < siz_n);
  end

  // no back-pressure, memory takes every request
  assign mem_vld     = vld;
  assign mem_req.wen = req.wen;
  // word index from the byte address
  assign mem_req.adr = req.adr[`TCB_ADR_W-1:`TCB_LO_W];

  ////////////////////
  // context
  ////////////////////

  // one response per request, next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctx_vld <= 1'b0;
    end else begin
      ctx_vld <= vld;
    end
  end

  // payload, loaded with each request
  always_ff @(posedge clk) begin
    if (vld) begin
      ctx.wen <= req.wen;
      ctx.ndn <= req.ndn;
      ctx.siz <= req.siz;
      ctx.lo  <= lo;
      ctx.mal <= mal;
    end
  end

endmodule

`default_nettype wire

// ==== hw/tcb_rsp_steer.sv ====
/* response steering, memory lanes back to reference mode
   right aligned read data, zero fill and error status */
`timescale 1ns/1ns
`default_nettype none

`include "tcb_consts.svh"

module tcb_rsp_steer
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  // registered transfer context
  input  logic     ctx_vld,
  input  tcb_ctx_t ctx,
  // memory read lanes
  input  mem_dat_t rdt,
  // reference side response
  output logic     rsp_vld,
  output tcb_rsp_t rsp
);

  // transfer size in bytes, zero for code 3
  logic [`TCB_LO_W:0] siz_n;
  // right aligned read bytes
  mem_dat_t           rdt_b;

  assign siz_n = (`TCB_LO_W+1)'(1) << ctx.siz;

  ////////////////////
  // read lanes
  ////////////////////

  for (genvar k = 0; k < `TCB_BEN; k++) begin : g_byte
    // lane holding right aligned byte k
    logic [`TCB_LO_W-1:0] sel;

    always_comb begin
      if (ctx.ndn) begin
        // big endian, lane lo+s-1-k
        sel = `TCB_LO_W'(ctx.lo + siz_n - 1 - k);
      end else begin
        // little endian, lane lo+k
        sel = `TCB_LO_W'(ctx.lo + k);
      end
    end

    // bytes above the size read as zero
    always_comb begin
      if ((`TCB_LO_W+1)'(k) < siz_n) begin
        rdt_b[k] = rdt[sel];
      end else begin
        rdt_b[k] = '0;
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  // fixed latency, response follows the context
  assign rsp_vld = ctx_vld;

  always_comb begin
    // writes and misaligned transfers return no data
    if (ctx.wen || ctx.mal) begin
      rsp.rdt = '0;
    end else begin
      rsp.rdt = rdt_b;
    end
    // error only on misalignment
    rsp.sts = ctx.mal;
  end

endmodule

`default_nettype wire

// ==== hw/tcb_subsys.sv ====
/* tightly coupled bus subsystem top
   request steering, memory and response steering */
`timescale 1ns/1ns
`default_nettype none

module tcb_subsys
  import tcb_bus_pkg::*;
  import tcb_mem_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  // manager request
  input  logic     vld,
  input  tcb_req_t req,
  // response, one cycle after the request
  output logic     rsp_vld,
  output tcb_rsp_t rsp
);

  ////////////////////
  // internal wires
  ////////////////////

  // memory side request
  logic     mem_vld;
  mem_req_t mem_req;
  // registered context
  logic     ctx_vld;
  tcb_ctx_t ctx;
  // memory read lanes
  mem_dat_t rdt;

  ////////////////////
  // instances
  ////////////////////

  // reference to memory mode, context stage
  tcb_req_steer u_req_steer (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .req     (req),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .ctx_vld (ctx_vld),
    .ctx     (ctx)
  );

  // runs side by side with the context stage
  tcb_mem u_mem (
    .clk     (clk),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .rdt     (rdt)
  );

  // lanes back to right aligned data
  tcb_rsp_steer u_rsp_steer (
    .ctx_vld (ctx_vld),
    .ctx     (ctx),
    .rdt     (rdt),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

// ==== sim/tcb_input_vectors.txt ====
# tag t: wen ndn siz adr wdt exp_rdt exp_sts, all hex, siz 0/1/2 = 1/2/4 bytes, 3 illegal
# tag s: section break with idle cycles, tag r: reset pulse, tag #: comment
# word writes then word reads, little endian, back to back
t 1 0 2 000 11223344 00000000 0
t 1 0 2 004 55667788 00000000 0
t 1 0 2 008 99aabbcc 00000000 0
t 1 0 2 ffc 0badf00d 00000000 0
t 0 0 2 000 00000000 11223344 0
t 0 0 2 004 00000000 55667788 0
t 0 0 2 008 00000000 99aabbcc 0
t 0 0 2 ffc 00000000 0badf00d 0
t 1 0 2 010 cafe1234 00000000 0
t 0 0 2 010 00000000 cafe1234 0
s
# byte and half-word writes at each aligned offset, little endian
t 1 0 2 020 a5a5a5a5 00000000 0
t 1 0 0 020 00000011 00000000 0
t 1 0 0 022 ffffff33 00000000 0
t 0 0 2 020 00000000 a533a511 0
t 1 0 0 021 00000022 00000000 0
t 1 0 0 023 00000044 00000000 0
t 0 0 2 020 00000000 44332211 0
t 1 0 2 024 a5a5a5a5 00000000 0
t 1 0 1 024 0000beef 00000000 0
t 0 0 2 024 00000000 a5a5beef 0
t 1 0 1 026 1234cafe 00000000 0
t 0 0 2 024 00000000 cafebeef 0
t 0 0 0 023 00000000 00000044 0
t 0 0 0 021 00000000 00000022 0
t 0 0 1 026 00000000 0000cafe 0
s
# big endian half-word, byte and word accesses
t 1 0 2 030 01020304 00000000 0
t 1 1 1 030 0000abcd 00000000 0
t 0 0 2 030 00000000 0102cdab 0
t 0 1 1 030 00000000 0000abcd 0
t 1 1 1 032 00001357 00000000 0
t 0 1 1 032 00000000 00001357 0
t 0 0 1 032 00000000 00005713 0
t 1 1 0 031 000000ee 00000000 0
t 0 1 0 031 00000000 000000ee 0
t 0 0 2 030 00000000 5713eeab 0
t 1 1 2 034 11223344 00000000 0
t 0 0 2 034 00000000 44332211 0
t 0 1 2 034 00000000 11223344 0
t 0 1 2 000 00000000 44332211 0
s
# misaligned accesses and size code 3, memory must stay unchanged
t 1 0 2 040 76543210 00000000 0
t 1 0 1 041 0000ffff 00000000 1
t 1 0 2 042 ffffffff 00000000 1
t 1 1 1 043 0000ffff 00000000 1
t 1 0 3 040 ffffffff 00000000 1
t 0 0 2 040 00000000 76543210 0
t 0 0 1 043 00000000 00000000 1
t 0 1 2 041 00000000 00000000 1
t 0 1 3 040 00000000 00000000 1
r
# after reset, earlier data still in memory
t 0 0 2 000 00000000 11223344 0
t 0 0 2 020 00000000 44332211 0
t 0 0 2 040 00000000 76543210 0
t 0 0 2 ffc 00000000 0badf00d 0
t 1 0 2 048 13579bdf 00000000 0
t 0 0 2 048 00000000 13579bdf 0

// ==== sim/tcb_subsys_tb.sv ====
/* tcb subsystem testbench
   reads transfers with expected responses from a vector file and checks each response */
`timescale 1ns/1ns
`default_nettype none

`include "tcb_consts.svh"

module tcb_subsys_tb
  import tcb_bus_pkg::*;
();

  localparam int    CLK_PERIOD  = 40;
  localparam int    DRV_DLY     = 2;
  localparam int    RST_CYCLES  = 3;
  // watchdog budget per vector line
  localparam int    CYC_PER_VEC = 10;
  localparam string VEC_FILE    = "sim/tcb_input_vectors.txt";

  // vector line kinds
  localparam logic [1:0] K_XFER = 2'd0;
  localparam logic [1:0] K_SECT = 2'd1;
  localparam logic [1:0] K_RST  = 2'd2;

  typedef struct packed {
    logic [1:0]            kind;
    tcb_req_t              req;
    logic [`TCB_DAT_W-1:0] rdt;
    logic                  sts;
  } vec_t;

  // one outstanding response
  typedef struct packed {
    logic [31:0]           due;
    logic [`TCB_DAT_W-1:0] rdt;
    logic                  sts;
  } exp_t;

  logic     clk;
  logic     arst_n;
  logic     vld;
  tcb_req_t req;
  logic     rsp_vld;
  tcb_rsp_t rsp;

  vec_t        vec_q [$];
  exp_t        exp_q [$];
  exp_t        rsp_exp;
  logic [31:0] cycle = '0;
  logic [31:0] rnd;
  int          n_rst = 0;
  int          n_checked = 0;
  int          value_errors = 0;
  int          proto_errors = 0;
  int          limit_cycles = 0;
  bit          loaded = 1'b0;
  bit          timed_out = 1'b0;

  tcb_subsys u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .vld     (vld),
    .req     (req),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  ////////////////////
  // clock and cycle count
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  ////////////////////
  // helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // t for a transfer, s for a section break, r for reset and # for a comment
  task automatic load_vectors();
    int                    fd;
    int                    n;
    bit                    done;
    logic [7:0]            tag;
    logic [8*200-1:0]      rest;
    logic                  wen;
    logic                  ndn;
    logic [1:0]            siz;
    logic [`TCB_ADR_W-1:0] adr;
    logic [`TCB_DAT_W-1:0] wdt;
    logic [`TCB_DAT_W-1:0] rdt;
    logic                  sts;
    vec_t                  v;
    done = 1'b0;
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      proto_errors++;
      $display("cannot open vector file %s", VEC_FILE);
    end else begin
      while (!done && $fscanf(fd, " %s", tag) == 1) begin
        v = '0;
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else if (tag == "s") begin
          v.kind = K_SECT;
          vec_q.push_back(v);
        end else if (tag == "r") begin
          v.kind = K_RST;
          vec_q.push_back(v);
          n_rst++;
        end else if (tag == "t") begin
          n = $fscanf(fd, " %h %h %h %h %h %h %h", wen, ndn, siz, adr, wdt, rdt, sts);
          if (n != 7) begin
            proto_errors++;
            $display("malformed transfer line in the vector file");
            done = 1'b1;
          end else begin
            v.kind    = K_XFER;
            v.req.wen = wen;
            v.req.ndn = ndn;
            v.req.siz = siz;
            v.req.adr = adr;
            v.req.wdt = wdt;
            v.rdt     = rdt;
            v.sts     = sts;
            vec_q.push_back(v);
          end
        end else begin
          proto_errors++;
          $display("unknown line tag in the vector file");
          done = 1'b1;
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // driver
  ////////////////////

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRV_DLY;
      vld = 1'b0;
      req = '0;
    end
  endtask

  // response due at the edge after the one that takes the request
  task automatic drive_transfer(input vec_t v);
    exp_t e;
    @(posedge clk);
    #DRV_DLY;
    vld   = 1'b1;
    req   = v.req;
    e.due = cycle + 1;
    e.rdt = v.rdt;
    e.sts = v.sts;
    exp_q.push_back(e);
  endtask

  // drain the queue and then hold reset for RST_CYCLES edges
  task automatic pulse_reset();
    idle_cycles(1);
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b0;
    // reads offered during reset get no response
    vld    = 1'b1;
    req    = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b1;
    vld    = 1'b0;
    req    = '0;
  endtask

  initial begin
    arst_n = 1'b0;
    vld    = 1'b0;
    req    = '0;
    rnd    = 32'h2ec4_bcf0;
    load_vectors();
    limit_cycles = vec_q.size() * CYC_PER_VEC + RST_CYCLES * (n_rst + 1);
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    arst_n = 1'b1;
    foreach (vec_q[i]) begin
      case (vec_q[i].kind)
        K_XFER: drive_transfer(vec_q[i]);
        K_SECT: begin
          // 1 to 4 idle cycles between sections
          rnd = xorshift32(rnd);
          idle_cycles(1 + int'(rnd[1:0]));
        end
        default: pulse_reset();
      endcase
    end
    idle_cycles(1);
    while (exp_q.size() != 0) @(posedge clk);
    // stray responses would still show up here
    idle_cycles(2);
    $display("errors: %0d value, %0d protocol, %0d responses checked",
             value_errors, proto_errors, n_checked);
    if (value_errors == 0 && proto_errors == 0 && !timed_out && n_checked > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  ////////////////////
  // response checker
  ////////////////////

  // sampled on the falling edge in mid cycle
  always @(negedge clk) begin
    if (rsp_vld) begin
      if (exp_q.size() == 0) begin
        proto_errors++;
        $display("response at %0t ns with no request outstanding", $time);
      end else begin
        rsp_exp = exp_q.pop_front();
        n_checked++;
        check_value("rsp cycle", cycle, rsp_exp.due);
        check_value("rsp.rdt", rsp.rdt, rsp_exp.rdt);
        check_value("rsp.sts", 32'(rsp.sts), 32'(rsp_exp.sts));
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
      proto_errors++;
      $display("no response at %0t ns for the request due in cycle %0d", $time, exp_q[0].due);
      void'(exp_q.pop_front());
    end
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    wait (loaded);
    #(limit_cycles * CLK_PERIOD);
    timed_out = 1'b1;
    $display("watchdog expired after %0d cycles, the run did not complete", limit_cycles);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/tcb_bus_pkg.sv
hw/tcb_mem_pkg.sv
hw/tcb_req_steer.sv
hw/tcb_mem.sv
hw/tcb_rsp_steer.sv
hw/tcb_subsys.sv
sim/tcb_subsys_tb.sv
